// File: compile.f
hw/bk_pkg.sv
hw/bk_trigger.sv
hw/bk_sequencer.sv
hw/bk_block_counter.sv
hw/bk_data_path.sv
hw/bk_save_top.sv
tests/tb_bk_save.sv

// File: hw/bk_block_counter.sv
`timescale 1ns/1ps

module bk_block_counter (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       clear,
	input  logic                       advance,
	input  logic                       rtc_inuse,
	input  logic [bk_pkg::BLOCK_W-1:0] ram_mask,
	output logic [bk_pkg::LBA_W-1:0]   lba,
	output logic                       last
);

	logic [bk_pkg::BLOCK_W-1:0] blk;

	assign blk = lba[bk_pkg::BLOCK_W-1:0];

	// With RTC in use one more block follows the save RAM
	always_comb begin
		if (rtc_inuse)
			last = (blk > ram_mask);
		else
			last = (blk >= ram_mask);
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			lba <= '0;
		end else if (clear) begin
			lba <= '0;
		end else if (advance) begin
			lba <= lba + 1'b1;
		end
	end

endmodule

// File: hw/bk_data_path.sv
`timescale 1ns/1ps

module bk_data_path (
	input  logic [bk_pkg::LBA_W-1:0]     lba,
	input  bk_pkg::sd_buf_t              sd_buf,
	input  logic [bk_pkg::BLOCK_W-1:0]   ram_mask,
	input  logic [bk_pkg::DATA_W-1:0]    bk_q,
	input  bk_pkg::rtc_save_t            rtc,
	output logic [bk_pkg::BK_ADDR_W-1:0] bk_addr,
	output logic [bk_pkg::DATA_W-1:0]    bk_data,
	output logic                         bk_wr,
	output logic                         bk_rtc_wr,
	output logic [bk_pkg::DATA_W-1:0]    sd_buff_din
);

	logic [bk_pkg::BLOCK_W-1:0] blk;
	logic                       is_ram;
	logic                       buf_we;

	assign blk    = lba[bk_pkg::BLOCK_W-1:0];
	assign is_ram = (blk <= ram_mask);
	assign buf_we = sd_buf.wr & sd_buf.ack;

	assign bk_addr = {blk, sd_buf.addr};
	assign bk_data = sd_buf.dout;

	// Blocks past the RAM size go to the RTC capture only
	assign bk_wr     = is_ram & buf_we;
	assign bk_rtc_wr = ~is_ram & buf_we;

	always_comb begin
		sd_buff_din = '1;
		if (is_ram) begin
			sd_buff_din = bk_q;
		end else if (sd_buf.addr < bk_pkg::RTC_WORDS) begin
			case (sd_buf.addr)
				8'd0:    sd_buff_din = rtc.timestamp[15:0];
				8'd1:    sd_buff_din = rtc.timestamp[31:16];
				8'd2:    sd_buff_din = rtc.savedtime[15:0];
				8'd3:    sd_buff_din = rtc.savedtime[31:16];
				8'd4:    sd_buff_din = rtc.savedtime[47:32];
			endcase
		end
	end

endmodule

// File: hw/bk_pkg.sv
package bk_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths

	// Block number inside the save image is the low bits of the host LBA
	localparam int BLOCK_W    = 8;
	localparam int LBA_W      = 32;

	// One block is 256 words of 16 bits
	localparam int BUF_ADDR_W = 8;
	localparam int DATA_W     = 16;

	// Save RAM word address is {block, word}
	localparam int BK_ADDR_W  = BLOCK_W + BUF_ADDR_W;

	// RTC fields kept in the extra block
	localparam int TS_W       = 32;
	localparam int SAVED_W    = 48;
	localparam int RTC_WORDS  = 5;

	////////////////////////////////////////////////////////////////////////////
	// Bundles

	// Block request towards the host
	typedef struct packed {
		logic             rd;
		logic             wr;
		logic [LBA_W-1:0] lba;
	} sd_req_t;

	// Host side of the block buffer
	typedef struct packed {
		logic                  ack;
		logic                  wr;
		logic [BUF_ADDR_W-1:0] addr;
		logic [DATA_W-1:0]     dout;
	} sd_buf_t;

	typedef struct packed {
		logic [TS_W-1:0]    timestamp;
		logic [SAVED_W-1:0] savedtime;
	} rtc_save_t;

	// Image flags as reported by the host
	typedef struct packed {
		logic mounted;
		logic readonly;
		logic has_size;
	} img_info_t;

	// Menu levels
	typedef struct packed {
		logic load;
		logic save;
		logic autosave_en;
	} bk_cmd_t;

endpackage

// File: hw/bk_save_top.sv
`timescale 1ns/1ps

module bk_save_top (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic                         downloading,
	input  logic                         cram_wr,
	input  logic                         osd_status,
	input  logic                         cart_has_save,
	input  logic                         rtc_inuse,
	input  bk_pkg::img_info_t            img,
	input  bk_pkg::bk_cmd_t              cmd,
	input  bk_pkg::sd_buf_t              sd_buf,
	input  bk_pkg::rtc_save_t            rtc,
	input  logic [bk_pkg::BLOCK_W-1:0]   ram_mask,
	input  logic [bk_pkg::DATA_W-1:0]    bk_q,
	output bk_pkg::sd_req_t              req,
	output logic [bk_pkg::BK_ADDR_W-1:0] bk_addr,
	output logic [bk_pkg::DATA_W-1:0]    bk_data,
	output logic                         bk_wr,
	output logic                         bk_rtc_wr,
	output logic [bk_pkg::DATA_W-1:0]    sd_buff_din,
	output logic                         busy,
	output logic                         loading,
	output logic                         led
);

	logic                     start;
	logic                     start_load;
	logic                     sav_pending;
	logic                     clear;
	logic                     advance;
	logic                     last;
	logic                     rd;
	logic                     wr;
	logic [bk_pkg::LBA_W-1:0] lba;

	////////////////////////////////////////////////////////////////////////////
	// Request side

	bk_trigger u_trigger (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.downloading   (downloading),
		.cram_wr       (cram_wr),
		.osd_status    (osd_status),
		.cart_has_save (cart_has_save),
		.busy          (busy),
		.img           (img),
		.cmd           (cmd),
		.start         (start),
		.start_load    (start_load),
		.sav_pending   (sav_pending)
	);

	bk_sequencer u_sequencer (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.start      (start),
		.start_load (start_load),
		.ack        (sd_buf.ack),
		.last       (last),
		.rd         (rd),
		.wr         (wr),
		.busy       (busy),
		.loading    (loading),
		.clear      (clear),
		.advance    (advance)
	);

	bk_block_counter u_block_counter (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.clear     (clear),
		.advance   (advance),
		.rtc_inuse (rtc_inuse),
		.ram_mask  (ram_mask),
		.lba       (lba),
		.last      (last)
	);

	assign req = '{rd: rd, wr: wr, lba: lba};

	////////////////////////////////////////////////////////////////////////////
	// Buffer side

	bk_data_path u_data_path (
		.lba         (lba),
		.sd_buf      (sd_buf),
		.ram_mask    (ram_mask),
		.bk_q        (bk_q),
		.rtc         (rtc),
		.bk_addr     (bk_addr),
		.bk_data     (bk_data),
		.bk_wr       (bk_wr),
		.bk_rtc_wr   (bk_rtc_wr),
		.sd_buff_din (sd_buff_din)
	);

	// User LED shows download activity or unsaved RAM
	assign led = downloading | sav_pending;

endmodule

// File: hw/bk_sequencer.sv
`timescale 1ns/1ps

module bk_sequencer (
	input  logic clk_sys,
	input  logic reset,
	input  logic start,
	input  logic start_load,
	input  logic ack,
	input  logic last,
	output logic rd,
	output logic wr,
	output logic busy,
	output logic loading,
	output logic clear,
	output logic advance
);

	typedef enum logic {
		st_idle,
		st_active
	} state_t;

	state_t state;
	logic   old_ack;
	logic   ack_rise;
	logic   ack_fall;

	assign ack_rise = ~old_ack & ack;
	assign ack_fall = old_ack & ~ack;

	assign busy    = (state == st_active);
	assign clear   = (state == st_idle) & start;
	assign advance = (state == st_active) & ack_fall & ~last;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= st_idle;
			old_ack <= 1'b0;
			rd      <= 1'b0;
			wr      <= 1'b0;
			loading <= 1'b0;
		end else begin
			old_ack <= ack;

			// Host took the request
			if (ack_rise) begin
				rd <= 1'b0;
				wr <= 1'b0;
			end

			case (state)
				st_idle: begin
					if (start) begin
						state   <= st_active;
						loading <= start_load;
						rd      <= start_load;
						wr      <= ~start_load;
					end
				end
				st_active: begin
					if (ack_fall) begin
						if (last) begin
							state   <= st_idle;
							loading <= 1'b0;
						end else begin
							rd <= loading;
							wr <= ~loading;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// File: hw/bk_trigger.sv
`timescale 1ns/1ps

module bk_trigger (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              downloading,
	input  logic              cram_wr,
	input  logic              osd_status,
	input  logic              cart_has_save,
	input  logic              busy,
	input  bk_pkg::img_info_t img,
	input  bk_pkg::bk_cmd_t   cmd,
	output logic              start,
	output logic              start_load,
	output logic              sav_pending
);

	logic old_downloading;
	logic old_load;
	logic old_save;
	logic bk_ena;
	logic new_load;

	logic sav_supported;
	logic load_cond;
	logic save_cond;
	logic dl_rise;
	logic dl_fall;
	logic load_rise;
	logic save_rise;
	logic auto_load;

	assign sav_supported = bk_ena & cart_has_save;

	// Level conditions whose edges are taken against the last cycle
	assign load_cond = cmd.load | new_load;
	assign save_cond = cmd.save | (sav_pending & osd_status & cmd.autosave_en);

	assign dl_rise   = ~old_downloading & downloading;
	assign dl_fall   = old_downloading & ~downloading;
	assign load_rise = ~old_load & load_cond;
	assign save_rise = ~old_save & save_cond;
	assign auto_load = dl_fall & img.has_size;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_downloading <= 1'b0;
			old_load        <= 1'b0;
			old_save        <= 1'b0;
			bk_ena          <= 1'b0;
			new_load        <= 1'b0;
			sav_pending     <= 1'b0;
			start           <= 1'b0;
			start_load      <= 1'b0;
		end else begin
			old_downloading <= downloading;
			old_load        <= load_cond;
			old_save        <= save_cond;

			// Save image is mounted by the end of the download
			if (dl_rise)
				bk_ena <= 1'b0;
			if (downloading && img.mounted && !img.readonly)
				bk_ena <= 1'b1;

			if (dl_fall && sav_supported)
				new_load <= 1'b1;
			else if (busy)
				new_load <= 1'b0;

			if (cram_wr && !osd_status && sav_supported)
				sav_pending <= 1'b1;
			else if (busy)
				sav_pending <= 1'b0;

			// One pulse per request; the held start covers the cycle before busy
			start <= bk_ena & ~busy & ~start & (load_rise | save_rise | auto_load);
			start_load <= load_rise | auto_load;
		end
	end

endmodule

// File: run.sh
#!/bin/bash
# Build and run the save engine testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
	--top-module tb_bk_save \
	-f compile.f \
	-Mdir obj_dir

./obj_dir/Vtb_bk_save > sim.log
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi
exit 0

// File: tests/tb_bk_save.sv
`timescale 1ns/1ps

module tb_bk_save;

	localparam int RAM_MASK        = 3;
	// Three RAM-only transfers and two with the extra RTC block
	localparam int NUM_BLOCKS      = 3 * (RAM_MASK + 1) + 2 * (RAM_MASK + 2);
	localparam int WATCHDOG_CYCLES = NUM_BLOCKS * 300 + 1000;

	logic                         clk_sys = 1'b0;
	logic                         reset;
	logic                         downloading;
	logic                         cram_wr;
	logic                         osd_status;
	logic                         cart_has_save;
	logic                         rtc_inuse;
	bk_pkg::img_info_t            img;
	bk_pkg::bk_cmd_t              cmd;
	bk_pkg::sd_buf_t              sd_buf;
	bk_pkg::rtc_save_t            rtc;
	logic [bk_pkg::BLOCK_W-1:0]   ram_mask;
	logic [bk_pkg::DATA_W-1:0]    bk_q;
	bk_pkg::sd_req_t              req;
	logic [bk_pkg::BK_ADDR_W-1:0] bk_addr;
	logic [bk_pkg::DATA_W-1:0]    bk_data;
	logic                         bk_wr;
	logic                         bk_rtc_wr;
	logic [bk_pkg::DATA_W-1:0]    sd_buff_din;
	logic                         busy;
	logic                         loading;
	logic                         led;

	int          errors = 0;
	int          checks = 0;
	logic [15:0] ram_key;

	bk_save_top uut (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.downloading   (downloading),
		.cram_wr       (cram_wr),
		.osd_status    (osd_status),
		.cart_has_save (cart_has_save),
		.rtc_inuse     (rtc_inuse),
		.img           (img),
		.cmd           (cmd),
		.sd_buf        (sd_buf),
		.rtc           (rtc),
		.ram_mask      (ram_mask),
		.bk_q          (bk_q),
		.req           (req),
		.bk_addr       (bk_addr),
		.bk_data       (bk_data),
		.bk_wr         (bk_wr),
		.bk_rtc_wr     (bk_rtc_wr),
		.sd_buff_din   (sd_buff_din),
		.busy          (busy),
		.loading       (loading),
		.led           (led)
	);

	always #5 clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////////////////////
	// Reference models

	// Save RAM contents depend on every address bit
	function automatic logic [15:0] ram_word(input logic [15:0] addr);
		ram_word = (addr * 16'd40503) ^ {addr[7:0], addr[15:8]} ^ ram_key;
	endfunction

	// RTC block holds the timestamp then the saved time, low word first
	function automatic logic [15:0] rtc_word(input int idx);
		logic [79:0] fields;
		fields = {rtc.savedtime, rtc.timestamp};
		if (idx < 5)
			rtc_word = fields[16*idx +: 16];
		else
			rtc_word = 16'hffff;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Host model

	task automatic apply_reset();
		reset = 1'b1;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
	endtask

	task automatic wait_request(output bit seen);
		int n;
		n = 0;
		seen = req.rd | req.wr;
		while (!seen && n < 10) begin
			@(negedge clk_sys);
			seen = req.rd | req.wr;
			n++;
		end
		if (!seen) begin
			errors++;
			$display("no block request from the DUT within 10 cycles at %0t", $time);
		end
	endtask

	task automatic run_block(input int blk, input bit is_load);
		logic [15:0] word;
		logic [15:0] addr;
		logic [15:0] expect_din;
		bit          seen;
		bit          is_ram;
		wait_request(seen);
		if (!seen)
			return;
		is_ram = (blk <= RAM_MASK);
		check_value("req.rd", req.rd, is_load);
		check_value("req.wr", req.wr, !is_load);
		check_value("req.lba", req.lba, blk);
		check_value("busy", busy, 1);
		sd_buf.ack = 1'b1;
		for (int i = 0; i < 256; i++) begin
			@(negedge clk_sys);
			word = 16'($urandom);
			addr = {8'(blk), 8'(i)};
			sd_buf.addr = 8'(i);
			if (is_load) begin
				sd_buf.wr   = 1'b1;
				sd_buf.dout = word;
			end else begin
				bk_q = ram_word(addr);
			end
			#1;
			check_value("bk_addr", bk_addr, addr);
			check_value("loading", loading, is_load);
			if (is_load) begin
				check_value("bk_data", bk_data, word);
				check_value("bk_wr", bk_wr, is_ram);
				check_value("bk_rtc_wr", bk_rtc_wr, !is_ram);
			end else begin
				expect_din = is_ram ? ram_word(addr) : rtc_word(i);
				check_value("sd_buff_din", sd_buff_din, expect_din);
				check_value("bk_wr", bk_wr, 0);
				check_value("bk_rtc_wr", bk_rtc_wr, 0);
			end
		end
		@(negedge clk_sys);
		// Request must have dropped on the ack edge
		check_value("req.rd", req.rd, 0);
		check_value("req.wr", req.wr, 0);
		sd_buf.wr  = 1'b0;
		sd_buf.ack = 1'b0;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy && n < 10) begin
			@(negedge clk_sys);
			n++;
		end
		if (busy) begin
			errors++;
			$display("busy did not return low after the last block at %0t", $time);
		end
	endtask

	task automatic run_transfer(input bit is_load, input int num_blocks);
		for (int b = 0; b < num_blocks; b++)
			run_block(b, is_load);
		wait_idle();
		check_value("req.rd", req.rd, 0);
		check_value("req.wr", req.wr, 0);
		check_value("loading", loading, 0);
	endtask

	task automatic pulse_download(input int cycles);
		@(negedge clk_sys);
		downloading = 1'b1;
		repeat (cycles) @(negedge clk_sys);
		downloading = 1'b0;
	endtask

	task automatic pulse_command(input bit is_load);
		@(negedge clk_sys);
		if (is_load)
			cmd.load = 1'b1;
		else
			cmd.save = 1'b1;
		repeat (2) @(negedge clk_sys);
		cmd.load = 1'b0;
		cmd.save = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests

	task automatic test_auto_load();
		img = '{mounted: 1'b1, readonly: 1'b0, has_size: 1'b1};
		cart_has_save = 1'b1;
		pulse_download(4);
		run_transfer(1'b1, RAM_MASK + 1);
	endtask

	task automatic test_manual_save();
		pulse_command(1'b0);
		run_transfer(1'b0, RAM_MASK + 1);
	endtask

	task automatic test_rtc_block();
		rtc.timestamp = $urandom;
		rtc.savedtime = {16'($urandom), $urandom};
		rtc_inuse = 1'b1;
		pulse_command(1'b1);
		run_transfer(1'b1, RAM_MASK + 2);
		pulse_command(1'b0);
		run_transfer(1'b0, RAM_MASK + 2);
		rtc_inuse = 1'b0;
	endtask

	task automatic test_autosave();
		@(negedge clk_sys);
		cram_wr = 1'b1;
		@(negedge clk_sys);
		cram_wr = 1'b0;
		check_value("led", led, 1);
		// Nothing may start while the menu is closed
		repeat (5) @(negedge clk_sys);
		check_value("busy", busy, 0);
		check_value("led", led, 1);
		osd_status      = 1'b1;
		cmd.autosave_en = 1'b1;
		run_transfer(1'b0, RAM_MASK + 1);
		check_value("led", led, 0);
		osd_status      = 1'b0;
		cmd.autosave_en = 1'b0;
	endtask

	task automatic test_blocked();
		img = '{mounted: 1'b1, readonly: 1'b1, has_size: 1'b1};
		pulse_download(4);
		@(negedge clk_sys);
		cmd.load = 1'b1;
		cram_wr  = 1'b1;
		@(negedge clk_sys);
		cram_wr = 1'b0;
		repeat (20) begin
			@(negedge clk_sys);
			check_value("req.rd", req.rd, 0);
			check_value("req.wr", req.wr, 0);
			check_value("led", led, 0);
		end
		cmd.load = 1'b0;
	endtask

	task automatic test_reset_state();
		bit seen;
		// Reset in the middle of a load with a save pending
		img = '{mounted: 1'b1, readonly: 1'b0, has_size: 1'b1};
		pulse_download(4);
		wait_request(seen);
		@(negedge clk_sys);
		cram_wr = 1'b1;
		@(negedge clk_sys);
		cram_wr = 1'b0;
		check_value("req.rd", req.rd, 1);
		check_value("busy", busy, 1);
		check_value("loading", loading, 1);
		check_value("led", led, 1);
		apply_reset();
		check_value("req.rd", req.rd, 0);
		check_value("req.wr", req.wr, 0);
		check_value("busy", busy, 0);
		check_value("loading", loading, 0);
		check_value("led", led, 0);
	endtask

	initial begin
		void'($urandom(9101));
		ram_key       = 16'($urandom);
		reset         = 1'b1;
		downloading   = 1'b0;
		cram_wr       = 1'b0;
		osd_status    = 1'b0;
		cart_has_save = 1'b0;
		rtc_inuse     = 1'b0;
		img           = '0;
		cmd           = '0;
		sd_buf        = '0;
		rtc           = '0;
		ram_mask      = RAM_MASK;
		bk_q          = '0;
		apply_reset();
		test_auto_load();
		test_manual_save();
		test_rtc_block();
		test_autosave();
		test_blocked();
		test_reset_state();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("simulation did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

endmodule
